// ==== build.f ====
+incdir+include
verilog/ifu_pkg.sv
verilog/fetch_stage.sv
verilog/icache_store.sv
verilog/icache_refill.sv
verilog/fetch_top.sv
verif/fetch_bus_model.sv
verif/fetch_chk.sv
verif/fetch_tb.sv

// ==== verif/fetch_tb.sv ====
`default_nettype none

`include "ifu_settings.svh"

module fetch_tb;

  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    logic [`IFU_ADDR_W-1:0] pc;
    logic [1:0]             reqs;   // Bus requests the fetch should cost
    logic [3:0]             stall;  // Cycles with next_ready_i low after valid_o rises
  } stim_t;

  localparam int N_ENTRIES = 15;
  localparam int CYCLES_PER_ENTRY = 40;
  localparam int TIMEOUT_CYCLES = N_ENTRIES * CYCLES_PER_ENTRY;
  localparam logic [`IFU_ADDR_W-1:0] FENCE_ADDR = 32'h0000_1010;
  localparam logic [`IFU_ADDR_W-1:0] DECOY_PC = 32'h0000_7ff0;

  logic                   clk;
  logic                   rst;
  logic [`IFU_ADDR_W-1:0] pc;
  logic                   prev_valid;
  logic                   ready;
  logic                   valid;
  logic [`IFU_ADDR_W-1:0] inst;
  logic [`IFU_ADDR_W-1:0] out_pc;
  logic                   next_ready;
  ifu_pkg::bus_ar_t       bus_ar;
  ifu_pkg::bus_r_t        bus_r;
  logic [31:0]            req_count;

  stim_t                  stim [0:N_ENTRIES-1];
  logic [`IFU_ADDR_W-1:0] req_addrs [$];
  int                     errors;
  int                     failed_tests;
  int                     cycles;

  fetch_top dut (
    .clk          (clk),
    .rst          (rst),
    .pc_i         (pc),
    .prev_valid_i (prev_valid),
    .ready_o      (ready),
    .valid_o      (valid),
    .inst_o       (inst),
    .pc_o         (out_pc),
    .next_ready_i (next_ready),
    .bus_ar_o     (bus_ar),
    .bus_r_i      (bus_r)
  );

  fetch_bus_model mem (
    .clk          (clk),
    .rst          (rst),
    .fence_addr_i (FENCE_ADDR),
    .bus_ar_i     (bus_ar),
    .bus_r_o      (bus_r),
    .req_count_o  (req_count)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // Requests last one cycle, so each is seen at exactly one falling edge
  always @(negedge clk)
  begin
    if (!rst && bus_ar.valid)
      req_addrs.push_back(bus_ar.addr);
  end

  function automatic logic [`IFU_ADDR_W-1:0] expected_word(input logic [`IFU_ADDR_W-1:0] addr);
    if ({addr[`IFU_ADDR_W-1:2], 2'b00} == FENCE_ADDR)
      return 32'h0000_100f;
    return {addr[`IFU_ADDR_W-1:7], 7'b0010011};
  endfunction

  function automatic stim_t make_entry(input logic [`IFU_ADDR_W-1:0] addr, input int reqs,
                                       input int stall);
    stim_t e;
    e.pc    = addr;
    e.reqs  = reqs[1:0];
    e.stall = stall[3:0];
    return e;
  endfunction

  task automatic show_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    $display("Mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
    errors++;
  endtask

  task automatic note_failure(input string what);
    $display("Failure at %0d ns: %s", $time, what);
    errors++;
  endtask

  task automatic load_table();
    stim[0]  = make_entry(32'h0000_1000, 2, 0);  // Cold miss
    stim[1]  = make_entry(32'h0000_1004, 0, 0);
    stim[2]  = make_entry(32'h0000_2000, 2, 0);  // Same set, other tag
    stim[3]  = make_entry(32'h0000_1000, 2, 0);
    stim[4]  = make_entry(32'h0000_1008, 2, 5);
    stim[5]  = make_entry(32'h0000_100c, 0, 3);
    stim[6]  = make_entry(FENCE_ADDR,    2, 2);  // FENCE.I empties the cache on handoff
    stim[7]  = make_entry(32'h0000_1004, 2, 0);
    stim[8]  = make_entry(32'h0000_1008, 2, 0);
    stim[9]  = make_entry(32'h0000_1014, 2, 0);
    stim[10] = make_entry(32'h0000_1018, 2, 0);
    stim[11] = make_entry(32'h0000_1000, 0, 0);
    stim[12] = make_entry(32'h0000_100c, 0, 4);
    stim[13] = make_entry(32'h0000_1014, 0, 0);
    stim[14] = make_entry(32'h0000_101c, 0, 0);
  endtask

  initial
  begin
    int                     i;
    int                     k;
    int                     errs_before;
    logic [31:0]            count_before;
    logic [`IFU_ADDR_W-1:0] held_inst;
    logic [`IFU_ADDR_W-1:0] held_pc;
    logic [`IFU_ADDR_W-1:0] line;

    errors       = 0;
    failed_tests = 0;
    cycles       = 0;
    rst          = 1'b1;
    pc           = '0;
    prev_valid   = 1'b0;
    next_ready   = 1'b0;
    load_table();

    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    if (valid) note_failure("valid_o high after reset");
    if (bus_ar.valid) note_failure("bus request valid high after reset");
    if (!ready) note_failure("ready_o low after reset");

    for (i = 0; i < N_ENTRIES; i++)
    begin
      errs_before  = errors;
      count_before = req_count;
      req_addrs.delete();
      if (!ready) note_failure("ready_o low while no PC is held");
      pc         = stim[i].pc;
      prev_valid = 1'b1;
      @(negedge clk);
      prev_valid = 1'b0;
      if (stim[i].reqs == 0 && !valid) note_failure("valid_o not high in the cycle after a hit");
      while (!valid)
        @(negedge clk);

      // A decoy PC offered during the stall must not be taken
      held_inst = inst;
      held_pc   = out_pc;
      for (k = 0; k < stim[i].stall; k++)
      begin
        pc         = DECOY_PC;
        prev_valid = 1'b1;
        @(negedge clk);
        if (!valid) note_failure("valid_o dropped during a stall");
        if (ready) note_failure("ready_o high during a stall");
        if (inst !== held_inst) show_mismatch("inst_o", inst, held_inst);
        if (out_pc !== held_pc) show_mismatch("pc_o", out_pc, held_pc);
      end
      prev_valid = 1'b0;

      if (inst !== expected_word(stim[i].pc))
        show_mismatch("inst_o", inst, expected_word(stim[i].pc));
      if (out_pc !== stim[i].pc) show_mismatch("pc_o", out_pc, stim[i].pc);
      if ((req_count - count_before) !== {30'b0, stim[i].reqs})
        show_mismatch("request count", req_count - count_before, {30'b0, stim[i].reqs});
      line = {stim[i].pc[`IFU_ADDR_W-1:3], 3'b000};
      if (stim[i].reqs == 2 && req_addrs.size() == 2)
      begin
        if (req_addrs[0] !== line) show_mismatch("even word address", req_addrs[0], line);
        if (req_addrs[1] !== (line | 32'h4))
          show_mismatch("odd word address", req_addrs[1], line | 32'h4);
      end

      next_ready = 1'b1;
      @(negedge clk);
      next_ready = 1'b0;
      if (valid) note_failure("valid_o still high after the handoff");

      if (errors == errs_before)
        $display("Entry %0d pc %h: %0d requests, %0d stall cycles, passed",
                 i, stim[i].pc, stim[i].reqs, stim[i].stall);
      else
      begin
        failed_tests++;
        $display("Entry %0d pc %h: failed", i, stim[i].pc);
      end
    end

    errors = errors + dut.u_chk.fail_count;
    $display("Entries run %0d, failed %0d, assertion failures %0d, total errors %0d",
             N_ENTRIES, failed_tests, dut.u_chk.fail_count, errors);
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/fetch_chk.sv ====
`default_nettype none

`include "ifu_settings.svh"

module fetch_chk (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     valid_i,
  input  wire                     ready_i,
  input  wire                     next_ready_i,
  input  wire [`IFU_ADDR_W-1:0]   out_inst_i,
  input  wire [`IFU_ADDR_W-1:0]   out_pc_i,
  input  ifu_pkg::bus_ar_t        bus_ar_i
);

  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_count = 0;

  no_req_while_valid: assert property (@(posedge clk) disable iff (rst)
    valid_i |-> !bus_ar_i.valid)
  else
  begin
    $error("Bus request issued while valid_o is high");
    fail_count++;
  end

  // A stalled instruction keeps its word and PC until the handoff
  stable_under_stall: assert property (@(posedge clk) disable iff (rst)
    valid_i && !next_ready_i |=> valid_i && $stable(out_inst_i) && $stable(out_pc_i))
  else
  begin
    $error("Output changed while valid_o was held by back-pressure");
    fail_count++;
  end

  // With no PC held there is nothing to hand off and no refill in flight
  idle_when_ready: assert property (@(posedge clk) disable iff (rst)
    ready_i |-> !valid_i && !bus_ar_i.valid)
  else
  begin
    $error("ready_o high together with valid_o or a bus request");
    fail_count++;
  end

endmodule

bind fetch_top fetch_chk u_chk (
  .clk          (clk),
  .rst          (rst),
  .valid_i      (valid_o),
  .ready_i      (ready_o),
  .next_ready_i (next_ready_i),
  .out_inst_i   (inst_o),
  .out_pc_i     (pc_o),
  .bus_ar_i     (bus_ar_o)
);

`default_nettype wire

// ==== verif/fetch_bus_model.sv ====
`default_nettype none

`include "ifu_settings.svh"

module fetch_bus_model (
  input  wire                     clk,
  input  wire                     rst,
  input  wire [`IFU_ADDR_W-1:0]   fence_addr_i,
  input  ifu_pkg::bus_ar_t        bus_ar_i,
  output ifu_pkg::bus_r_t         bus_r_o,
  output logic [31:0]             req_count_o
);

  timeunit 1ns;
  timeprecision 100ps;

  integer                 seed;
  logic [2:0]             delay_q;  // Cycles left until the response or 0 when idle
  logic [`IFU_ADDR_W-1:0] addr_q;

  initial seed = 32'h9f03_5107;

  function automatic logic [`IFU_ADDR_W-1:0] mem_word(input logic [`IFU_ADDR_W-1:0] addr);
    if (addr == fence_addr_i)
      return 32'h0000_100f;
    return {addr[`IFU_ADDR_W-1:7], 7'b0010011};  // OP-IMM opcode over the address bits
  endfunction

  always @(posedge clk)
  begin
    if (rst)
    begin
      bus_r_o     <= '0;
      delay_q     <= '0;
      addr_q      <= '0;
      req_count_o <= '0;
    end
    else
    begin
      bus_r_o.valid <= 1'b0;
      if (bus_ar_i.valid)
      begin
        addr_q      <= bus_ar_i.addr;
        delay_q     <= 3'(($random(seed) & 3) + 1);  // One to four cycles
        req_count_o <= req_count_o + 1;
      end
      else if (delay_q == 3'd1)
      begin
        bus_r_o.valid <= 1'b1;
        bus_r_o.data  <= mem_word(addr_q);
        delay_q       <= '0;
      end
      else if (delay_q != 3'd0)
        delay_q <= delay_q - 1;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/fetch_top.sv ====
`default_nettype none

`include "ifu_settings.svh"

module fetch_top (
  input  wire                     clk,
  input  wire                     rst,
  input  wire [`IFU_ADDR_W-1:0]   pc_i,
  input  wire                     prev_valid_i,
  output logic                    ready_o,
  output logic                    valid_o,
  output logic [`IFU_ADDR_W-1:0]  inst_o,
  output logic [`IFU_ADDR_W-1:0]  pc_o,
  input  wire                     next_ready_i,
  output ifu_pkg::bus_ar_t        bus_ar_o,
  input  ifu_pkg::bus_r_t         bus_r_i
);

  ifu_pkg::cache_addr_t   held_pc;
  ifu_pkg::inst_u         word;
  logic                   pending;
  logic                   hit;
  logic                   flush;
  logic                   fill;
  logic                   fill_sel;
  logic [`IFU_ADDR_W-1:0] fill_data;

  fetch_stage u_stage (
    .clk          (clk),
    .rst          (rst),
    .pc_i         (pc_i),
    .prev_valid_i (prev_valid_i),
    .next_ready_i (next_ready_i),
    .hit_i        (hit),
    .word_i       (word),
    .ready_o      (ready_o),
    .valid_o      (valid_o),
    .inst_o       (inst_o),
    .pc_o         (pc_o),
    .pending_o    (pending),
    .held_pc_o    (held_pc),
    .flush_o      (flush)
  );

  icache_store u_store (
    .clk         (clk),
    .rst         (rst),
    .lookup_i    (held_pc),
    .fill_i      (fill),
    .fill_sel_i  (fill_sel),
    .fill_data_i (fill_data),
    .flush_i     (flush),
    .hit_o       (hit),
    .word_o      (word)
  );

  icache_refill u_refill (
    .clk         (clk),
    .rst         (rst),
    .pending_i   (pending),
    .hit_i       (hit),
    .miss_addr_i (held_pc),
    .bus_ar_o    (bus_ar_o),
    .bus_r_i     (bus_r_i),
    .fill_o      (fill),
    .fill_sel_o  (fill_sel),
    .fill_data_o (fill_data)
  );

endmodule

`default_nettype wire

// ==== verilog/icache_refill.sv ====
`default_nettype none

`include "ifu_settings.svh"

module icache_refill (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         pending_i,
  input  wire                         hit_i,
  input  ifu_pkg::cache_addr_t        miss_addr_i,
  output ifu_pkg::bus_ar_t            bus_ar_o,
  input  ifu_pkg::bus_r_t             bus_r_i,
  output logic                        fill_o,
  output logic                        fill_sel_o,
  output logic [`IFU_ADDR_W-1:0]      fill_data_o
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_REQ0,
    ST_WAIT0,
    ST_REQ1,
    ST_WAIT1
  } state_t;

  state_t               state_q;
  state_t               state_d;
  ifu_pkg::cache_addr_t req_addr;
  logic                 in_wait;

  always_ff @(posedge clk)
  begin
    if (rst)
      state_q <= ST_IDLE;
    else
      state_q <= state_d;
  end

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:
      begin
        if (pending_i && !hit_i)
          state_d = ST_REQ0;
      end
      ST_REQ0:
        state_d = ST_WAIT0;  // Request lasts exactly one cycle
      ST_WAIT0:
      begin
        if (bus_r_i.valid)
          state_d = ST_REQ1;
      end
      ST_REQ1:
        state_d = ST_WAIT1;
      ST_WAIT1:
      begin
        if (bus_r_i.valid)
          state_d = ST_IDLE;  // Line is valid from the next cycle on
      end
      default:
        state_d = ST_IDLE;
    endcase
  end

  // Line-aligned address with the word picked by the request state
  always_comb
  begin
    req_addr          = miss_addr_i;
    req_addr.byte_ofs = '0;
    if (state_q == ST_REQ1)
      req_addr.offset = `IFU_OFFSET_W'(1);
    else
      req_addr.offset = '0;
  end

  always_comb
  begin
    bus_ar_o.valid = (state_q == ST_REQ0) || (state_q == ST_REQ1);
    bus_ar_o.addr  = req_addr;
  end

  assign in_wait = (state_q == ST_WAIT0) || (state_q == ST_WAIT1);

  // Each response becomes one fill write
  assign fill_o      = in_wait & bus_r_i.valid;
  assign fill_sel_o  = (state_q == ST_WAIT1);
  assign fill_data_o = bus_r_i.data;

endmodule

`default_nettype wire

// ==== verilog/icache_store.sv ====
`default_nettype none

`include "ifu_settings.svh"

module icache_store (
  input  wire                         clk,
  input  wire                         rst,
  input  ifu_pkg::cache_addr_t        lookup_i,
  input  wire                         fill_i,
  input  wire                         fill_sel_i,
  input  wire [`IFU_ADDR_W-1:0]       fill_data_i,
  input  wire                         flush_i,
  output logic                        hit_o,
  output ifu_pkg::inst_u              word_o
);

  ifu_pkg::inst_u          data_q [0:`IFU_SETS-1][0:`IFU_LINE_WORDS-1];
  logic [`IFU_TAG_W-1:0]   tag_q  [0:`IFU_SETS-1];
  logic [`IFU_SETS-1:0]    valid_q;

  logic [`IFU_INDEX_W-1:0] idx;
  logic                    line_done;

  assign idx = lookup_i.index;

  // The second word closes the line
  assign line_done = fill_i & fill_sel_i;

  always_ff @(posedge clk)
  begin
    if (fill_i)
      data_q[idx][fill_sel_i].raw <= fill_data_i;
  end

  always_ff @(posedge clk)
  begin
    if (line_done)
      tag_q[idx] <= lookup_i.tag;
  end

  always_ff @(posedge clk)
  begin
    if (rst || flush_i)
      valid_q <= '0;
    else if (line_done)
      valid_q[idx] <= 1'b1;
  end

  assign hit_o  = valid_q[idx] && (tag_q[idx] == lookup_i.tag);
  assign word_o = data_q[idx][lookup_i.offset];

endmodule

`default_nettype wire

// ==== verilog/fetch_stage.sv ====
`default_nettype none

`include "ifu_settings.svh"

module fetch_stage (
  input  wire                     clk,
  input  wire                     rst,
  input  wire [`IFU_ADDR_W-1:0]   pc_i,
  input  wire                     prev_valid_i,
  input  wire                     next_ready_i,
  input  wire                     hit_i,
  input  ifu_pkg::inst_u          word_i,
  output logic                    ready_o,
  output logic                    valid_o,
  output logic [`IFU_ADDR_W-1:0]  inst_o,
  output logic [`IFU_ADDR_W-1:0]  pc_o,
  output logic                    pending_o,
  output ifu_pkg::cache_addr_t    held_pc_o,
  output logic                    flush_o
);

  logic                 pending_q;
  ifu_pkg::cache_addr_t pc_q;
  logic                 accept;
  logic                 handoff;
  logic                 is_fence_i;

  assign accept  = prev_valid_i & ready_o;
  assign handoff = valid_o & next_ready_i;

  always_ff @(posedge clk)
  begin
    if (rst)
      pending_q <= 1'b0;
    else if (accept)
      pending_q <= 1'b1;
    else if (handoff)
      pending_q <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      pc_q <= pc_i;
  end

  assign ready_o = ~pending_q;  // One PC in flight at a time
  assign valid_o = pending_q & hit_i;

  assign inst_o    = word_i.raw;
  assign pc_o      = pc_q;
  assign pending_o = pending_q;
  assign held_pc_o = pc_q;

  // Decode only the fields that identify FENCE.I
  assign is_fence_i = (word_i.f.opcode == `IFU_OP_MISC_MEM) &&
                      (word_i.f.funct3 == `IFU_F3_FENCE_I);

  assign flush_o = handoff & is_fence_i;  // Store drops all lines at the handoff edge

endmodule

`default_nettype wire

// ==== verilog/ifu_pkg.sv ====
`default_nettype none

`include "ifu_settings.svh"

package ifu_pkg;

  typedef struct packed {
    logic                   valid;  // Single-cycle request pulse
    logic [`IFU_ADDR_W-1:0] addr;
  } bus_ar_t;

  typedef struct packed {
    logic                   valid;  // Single-cycle response pulse
    logic [`IFU_ADDR_W-1:0] data;
  } bus_r_t;

  typedef struct packed {
    logic [`IFU_TAG_W-1:0]    tag;
    logic [`IFU_INDEX_W-1:0]  index;
    logic [`IFU_OFFSET_W-1:0] offset;
    logic [`IFU_BYTE_W-1:0]   byte_ofs;
  } cache_addr_t;

  typedef struct packed {
    logic [16:0] upper;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } inst_fields_t;

  typedef union packed {
    logic [`IFU_ADDR_W-1:0] raw;
    inst_fields_t           f;
  } inst_u;

endpackage

`default_nettype wire

// ==== include/ifu_settings.svh ====
`ifndef IFU_SETTINGS_SVH
`define IFU_SETTINGS_SVH

// Address and data width of the core and the fetch bus
`define IFU_ADDR_W 32

// Cache geometry of four sets with two-word lines
`define IFU_OFFSET_W 1
`define IFU_INDEX_W 2
`define IFU_BYTE_W 2
`define IFU_TAG_W (`IFU_ADDR_W - `IFU_INDEX_W - `IFU_OFFSET_W - `IFU_BYTE_W)

`define IFU_LINE_WORDS (1 << `IFU_OFFSET_W)
`define IFU_SETS (1 << `IFU_INDEX_W)

// FENCE.I is MISC-MEM with funct3 001
`define IFU_OP_MISC_MEM 7'b0001111
`define IFU_F3_FENCE_I 3'b001

`endif
